/* bench/colmix_stim.txt */
// op addr_or_gfx1 data_or_gfx2 flag, all hex
// op 1 APB write, op 2 APB read with expected data, flag is pslverr; op 3 pixel, flag is {hblank_n, vblank_n}
1 024 0A5 0
1 025 03E 0
1 16A 01F 0
1 16B 07C 0
1 100 042 0
1 101 001 0
1 224 0E0 0
1 225 003 0
2 024 0A5 0
2 16B 07C 0
2 400 000 0
// Unmapped accesses
1 824 0FF 1
1 401 003 1
2 024 0A5 0
2 400 000 0
2 401 000 1
// Priority 0, then blanking
3 012 035 3
3 010 035 3
3 000 000 3
3 012 035 1
3 012 035 2
3 012 035 3
// Priority 1
1 400 001 0
2 400 001 0
3 012 035 3
3 012 030 3
// Bank 1
1 400 002 0
2 400 002 0
3 012 035 3
3 012 000 3
// Palette rewrite
1 400 000 0
1 024 01B 0
3 012 035 3
3 010 035 3
3 012 035 3
2 024 01B 0

/* colmix_top.f */
+incdir+common
common/colmix_pkg.sv
logic/palette_ram.sv
colmix/colmix_regs.sv
colmix/layer_priority.sv
colmix/palette_fetch.sv
logic/blank_delay.sv
logic/colmix_top.sv
bench/colmix_check.sv
bench/colmix_tb.sv

/* bench/colmix_tb.sv */
//--------------------
// Testbench for the colour mixer top level
// Replays APB transfers and pixel vectors from the stim file
// Comparison is done by the checker module
//--------------------
`default_nettype none
`include "colmix_consts.svh"

module colmix_tb;

    localparam int STIM_WORDS = 512;
    localparam int FIELDS     = 4;

    logic                      clk;
    logic                      rst;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`COLMIX_ADDR_W-1:0] paddr;
    logic [7:0]                pwdata;
    logic [7:0]                prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      pxl_cen;
    logic                      hblank_n;
    logic                      vblank_n;
    colmix_pkg::pixel_t        gfx1_pxl;
    colmix_pkg::pixel_t        gfx2_pxl;
    logic                      hblank_dly_n;
    logic                      vblank_dly_n;
    logic [4:0]                red;
    logic [4:0]                green;
    logic [4:0]                blue;
    // Expected read data and error flag for the checker
    logic [7:0]                exp_rdata;
    logic                      exp_err;

    // Four fields per line: op, address or gfx1, data or gfx2, flag
    logic [11:0]               stim [STIM_WORDS];
    int                        line_count;
    int                        cycle_limit;
    int                        cycles;
    int                        stim_errors;
    int                        error_count;
    int                        check_count;
    int                        idx;

    colmix_top colmix_top_inst (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .pxl_cen      (pxl_cen),
        .hblank_n     (hblank_n),
        .vblank_n     (vblank_n),
        .gfx1_pxl     (gfx1_pxl),
        .gfx2_pxl     (gfx2_pxl),
        .hblank_dly_n (hblank_dly_n),
        .vblank_dly_n (vblank_dly_n),
        .red          (red),
        .green        (green),
        .blue         (blue)
    );

    colmix_check check_inst (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .exp_rdata    (exp_rdata),
        .exp_err      (exp_err),
        .pxl_cen      (pxl_cen),
        .hblank_n     (hblank_n),
        .vblank_n     (vblank_n),
        .gfx1_pxl     (gfx1_pxl),
        .gfx2_pxl     (gfx2_pxl),
        .hblank_dly_n (hblank_dly_n),
        .vblank_dly_n (vblank_dly_n),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Pixel enable on every second clock
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            #5;
            pxl_cen = ~pxl_cen;
        end
    end

    // Blanks the picture first so the last visible pixel finishes its fetch
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [7:0] data, input logic err);
        @(posedge clk);
        #5;
        hblank_n = 1'b0;
        do begin
            @(posedge clk);
        end while (!pxl_cen);
        // Setup phase
        #5;
        psel      = 1'b1;
        pwrite    = write;
        paddr     = addr;
        pwdata    = write ? data : 8'h00;
        exp_rdata = data;
        exp_err   = err;
        @(posedge clk);
        #5;
        penable = 1'b1;
        do begin
            @(posedge clk);
        end while (!pready);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // New pixel lands on the next pixel enable edge
    task automatic show_pixel(input logic [6:0] g1, input logic [6:0] g2,
                              input logic [1:0] flags);
        @(posedge clk);
        if (pxl_cen) begin
            @(posedge clk);
        end
        #5;
        gfx1_pxl = g1;
        gfx2_pxl = g2;
        hblank_n = flags[1];
        vblank_n = flags[0];
        @(posedge clk);
    endtask

    task automatic run_line(input int n);
        logic [11:0] op;
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] c;
        op = stim[n * FIELDS];
        a  = stim[n * FIELDS + 1];
        b  = stim[n * FIELDS + 2];
        c  = stim[n * FIELDS + 3];
        case (op)
            12'h1: apb_transfer(1'b1, a, b[7:0], c[0]);
            12'h2: apb_transfer(1'b0, a, b[7:0], c[0]);
            12'h3: show_pixel(a[6:0], b[6:0], c[1:0]);
            default: begin
                stim_errors++;
                $display("Unknown operation %0h on stimulus line %0d", op, n);
            end
        endcase
    endtask

    initial begin
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = 8'h00;
        hblank_n  = 1'b0;
        vblank_n  = 1'b0;
        gfx1_pxl  = '0;
        gfx2_pxl  = '0;
        exp_rdata = 8'h00;
        exp_err   = 1'b0;
        stim_errors = 0;
        for (idx = 0; idx < STIM_WORDS; idx++) begin
            stim[idx] = '0;
        end
        $readmemh("bench/colmix_stim.txt", stim);
        // Op 0 ends the list
        line_count = 0;
        while (line_count < STIM_WORDS / FIELDS && stim[line_count * FIELDS] != '0) begin
            line_count++;
        end
        cycle_limit = 2 * line_count * 4 + 100;
        if (line_count == 0) begin
            stim_errors++;
            $display("No stimulus lines could be read from the stim file");
        end
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        for (idx = 0; idx < line_count; idx++) begin
            run_line(idx);
        end
        // Let the last pixels reach the outputs
        repeat (2 * `COLMIX_BLANK_DLY + 4) @(posedge clk);
        $display("Checks: %0d, errors: %0d, stimulus errors: %0d",
                 check_count, error_count, stim_errors);
        if (error_count == 0 && stim_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Cycle limit follows the stimulus length
    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d checks and %0d errors, stimulus unfinished",
                 cycles, check_count, error_count);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/colmix_check.sv */
//--------------------
// Watches the APB and video ports of the colour mixer
// Keeps its own palette and control copy, checks transfers and pixels
//--------------------
`default_nettype none
`include "colmix_consts.svh"

module colmix_check (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      psel,
    input  wire                      penable,
    input  wire                      pwrite,
    input  wire [`COLMIX_ADDR_W-1:0] paddr,
    input  wire [7:0]                pwdata,
    input  wire [7:0]                prdata,
    input  wire                      pready,
    input  wire                      pslverr,
    input  wire [7:0]                exp_rdata,
    input  wire                      exp_err,
    input  wire                      pxl_cen,
    input  wire                      hblank_n,
    input  wire                      vblank_n,
    input  wire colmix_pkg::pixel_t  gfx1_pxl,
    input  wire colmix_pkg::pixel_t  gfx2_pxl,
    input  wire                      hblank_dly_n,
    input  wire                      vblank_dly_n,
    input  wire [4:0]                red,
    input  wire [4:0]                green,
    input  wire [4:0]                blue,
    output int                       error_count,
    output int                       check_count
);

    localparam int DLY = `COLMIX_BLANK_DLY;

    logic [7:0]  pal_mem [`COLMIX_PAL_BYTES];
    logic        prio_q;
    logic        bank_q;
    logic        cen_q;
    int          wait_cnt;
    int          fill_idx;
    // Per pixel: hblank, vblank, blue, green, red
    logic [16:0] exp_q [$];

    initial begin
        error_count = 0;
        check_count = 0;
        for (fill_idx = 0; fill_idx < `COLMIX_PAL_BYTES; fill_idx++) begin
            pal_mem[fill_idx] = fill_idx[7:0] ^ {6'h00, fill_idx[9:8]};
        end
    end

    task automatic report_error(input string msg);
        error_count++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    // Front layer number equals prio
    function automatic logic [14:0] expected_colour(input colmix_pkg::pixel_t g1,
                                                    input colmix_pkg::pixel_t g2);
        colmix_pkg::pixel_t    front_pxl;
        logic                  layer;
        colmix_pkg::pal_addr_t base;
        logic [7:0]            even_b;
        logic [7:0]            odd_b;
        front_pxl = prio_q ? g2 : g1;
        layer     = (front_pxl[3:0] != 4'h0) ? prio_q : !prio_q;
        base      = {bank_q, layer, layer ? g2 : g1, 1'b0};
        even_b    = pal_mem[base];
        odd_b     = pal_mem[{base[9:1], 1'b1}];
        // Blue, then green split over both bytes, then red
        return {odd_b[6:2], odd_b[1:0], even_b[7:5], even_b[4:0]};
    endfunction

    task automatic check_transfer();
        logic pal_hit;
        logic ctrl_hit;
        int   exp_wait;
        pal_hit  = paddr < `COLMIX_PAL_BYTES;
        ctrl_hit = paddr == `COLMIX_CTRL_ADDR;
        // Only palette reads wait for the RAM
        exp_wait = (pal_hit && !pwrite) ? 1 : 0;
        check_count++;
        if (wait_cnt != exp_wait) begin
            report_error($sformatf("%0d wait states at addr %h, expected %0d",
                                   wait_cnt, paddr, exp_wait));
        end
        if (pslverr !== exp_err) begin
            report_error($sformatf("pslverr %b at addr %h, expected %b", pslverr, paddr, exp_err));
        end
        if (!pwrite && prdata !== exp_rdata) begin
            report_error($sformatf("prdata %h at addr %h, expected %h", prdata, paddr, exp_rdata));
        end
        // Unmapped writes leave both copies alone
        if (pwrite && pal_hit) begin
            pal_mem[paddr[9:0]] = pwdata;
        end
        if (pwrite && ctrl_hit) begin
            prio_q = pwdata[`COLMIX_CTRL_PRIO_BIT];
            bank_q = pwdata[`COLMIX_CTRL_BANK_BIT];
        end
    endtask

    always @(posedge clk) begin
        logic [16:0] exp_v;
        logic [14:0] colour;
        if (rst) begin
            prio_q   = 1'b0;
            bank_q   = 1'b0;
            cen_q    = 1'b0;
            wait_cnt = 0;
            exp_q.delete();
            // Blank and black until the first pixel gets through
            repeat (DLY) exp_q.push_back('0);
        end else begin
            // Output stage changed on the previous edge
            if (cen_q && exp_q.size() > DLY) begin
                exp_v = exp_q.pop_front();
                check_count++;
                if ({hblank_dly_n, vblank_dly_n, blue, green, red} !== exp_v) begin
                    report_error($sformatf(
                        "video h%b v%b rgb %h %h %h, expected h%b v%b rgb %h %h %h",
                        hblank_dly_n, vblank_dly_n, red, green, blue,
                        exp_v[16], exp_v[15], exp_v[4:0], exp_v[9:5], exp_v[14:10]));
                end
            end
            cen_q = pxl_cen;
            // Sampled with the control value from before this edge
            if (pxl_cen) begin
                colour = (hblank_n && vblank_n) ? expected_colour(gfx1_pxl, gfx2_pxl) : 15'h0;
                exp_q.push_back({hblank_n, vblank_n, colour});
            end
            if (psel && penable) begin
                if (pready) begin
                    check_transfer();
                    wait_cnt = 0;
                end else begin
                    wait_cnt++;
                end
            end else if (pready) begin
                report_error("pready high outside the access phase");
            end
        end
    end

endmodule

`default_nettype wire

/* logic/colmix_top.sv */
//--------------------
// Colour mixer top level
// APB palette access, layer priority, palette fetch, blanking
//--------------------
`default_nettype none
`include "colmix_consts.svh"

module colmix_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      psel,
    input  wire                      penable,
    input  wire                      pwrite,
    input  wire [`COLMIX_ADDR_W-1:0] paddr,
    input  wire [7:0]                pwdata,
    output logic [7:0]               prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  wire                      pxl_cen,
    input  wire                      hblank_n,
    input  wire                      vblank_n,
    input  wire colmix_pkg::pixel_t  gfx1_pxl,
    input  wire colmix_pkg::pixel_t  gfx2_pxl,
    output logic                     hblank_dly_n,
    output logic                     vblank_dly_n,
    output logic [4:0]               red,
    output logic [4:0]               green,
    output logic [4:0]               blue
);

    // Host port
    logic                   host_we;
    colmix_pkg::pal_addr_t  host_addr;
    logic [7:0]             host_wdata;
    logic [7:0]             host_rdata;
    // Control levels
    logic                   prio_mode;
    logic                   pal_bank;
    // Video path
    colmix_pkg::pal_index_t pal_index;
    colmix_pkg::pal_addr_t  vid_addr;
    logic [7:0]             vid_rdata;
    colmix_pkg::rgb_t       rgb_raw;

    colmix_regs regs_inst (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .prio_mode  (prio_mode),
        .pal_bank   (pal_bank)
    );

    layer_priority priority_inst (
        .clk       (clk),
        .pxl_cen   (pxl_cen),
        .gfx1_pxl  (gfx1_pxl),
        .gfx2_pxl  (gfx2_pxl),
        .prio_mode (prio_mode),
        .pal_bank  (pal_bank),
        .pal_index (pal_index)
    );

    palette_ram ram_inst (
        .clk        (clk),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .vid_addr   (vid_addr),
        .vid_rdata  (vid_rdata)
    );

    palette_fetch fetch_inst (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pal_index (pal_index),
        .vid_addr  (vid_addr),
        .vid_rdata (vid_rdata),
        .rgb_raw   (rgb_raw)
    );

    blank_delay blank_inst (
        .clk          (clk),
        .rst          (rst),
        .pxl_cen      (pxl_cen),
        .hblank_n     (hblank_n),
        .vblank_n     (vblank_n),
        .rgb_raw      (rgb_raw),
        .hblank_dly_n (hblank_dly_n),
        .vblank_dly_n (vblank_dly_n),
        .red          (red),
        .green        (green),
        .blue         (blue)
    );

endmodule

`default_nettype wire

/* logic/blank_delay.sv */
//--------------------
// Delays the blanking flags to line up with the fetched colour
// Output stage forces black while either flag is low
//--------------------
`default_nettype none
`include "colmix_consts.svh"

module blank_delay (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   pxl_cen,
    input  wire                   hblank_n,
    input  wire                   vblank_n,
    input  wire colmix_pkg::rgb_t rgb_raw,
    output logic                  hblank_dly_n,
    output logic                  vblank_dly_n,
    output logic [4:0]            red,
    output logic [4:0]            green,
    output logic [4:0]            blue
);

    localparam int DLY = `COLMIX_BLANK_DLY;

    logic [DLY-1:0]   hb_line;
    logic [DLY-1:0]   vb_line;
    colmix_pkg::rgb_t rgb_out;

    // Flags sampled with the layer pixels
    // Colour reaches rgb_raw two enables later through the fetch path
    always_ff @(posedge clk) begin
        if (rst) begin
            hb_line      <= '0;
            vb_line      <= '0;
            hblank_dly_n <= 1'b0;
            vblank_dly_n <= 1'b0;
            rgb_out      <= '0;
        end else if (pxl_cen) begin
            hb_line      <= {hb_line[DLY-2:0], hblank_n};
            vb_line      <= {vb_line[DLY-2:0], vblank_n};
            hblank_dly_n <= hb_line[DLY-1];
            vblank_dly_n <= vb_line[DLY-1];
            // Black while blanked
            rgb_out      <= (hb_line[DLY-1] && vb_line[DLY-1]) ? rgb_raw : '0;
        end
    end

    assign {blue, green, red} = rgb_out;

endmodule

`default_nettype wire

/* colmix/palette_fetch.sv */
//--------------------
// Reads the two palette bytes of each pixel on the video port
// Low byte first, high byte next, colour out at the next pixel enable
//--------------------
`default_nettype none

module palette_fetch (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pxl_cen,
    input  wire colmix_pkg::pal_index_t pal_index,
    output colmix_pkg::pal_addr_t       vid_addr,
    input  wire [7:0]                   vid_rdata,
    output colmix_pkg::rgb_t            rgb_raw
);

    colmix_pkg::fetch_state_t state;
    logic                     lo_valid;
    logic                     hi_valid;
    logic [7:0]               stage_lo;
    logic [7:0]               stage_hi;

    // Even byte in FETCH_LOW, odd byte in FETCH_HIGH
    assign vid_addr = {pal_index, state == colmix_pkg::FETCH_HIGH};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= colmix_pkg::FETCH_IDLE;
            lo_valid <= 1'b0;
            hi_valid <= 1'b0;
            rgb_raw  <= '0;
        end else begin
            // RAM data lags the address by one clock
            lo_valid <= state == colmix_pkg::FETCH_LOW;
            hi_valid <= state == colmix_pkg::FETCH_HIGH;
            case (state)
                colmix_pkg::FETCH_IDLE: begin
                    if (pxl_cen) begin
                        state <= colmix_pkg::FETCH_LOW;
                    end
                end
                colmix_pkg::FETCH_LOW: begin
                    state <= colmix_pkg::FETCH_HIGH;
                end
                colmix_pkg::FETCH_HIGH: begin
                    state <= pxl_cen ? colmix_pkg::FETCH_LOW : colmix_pkg::FETCH_IDLE;
                end
                default: begin
                    state <= colmix_pkg::FETCH_IDLE;
                end
            endcase
            // Odd byte is 0, blue, green[4:3]; even byte is green[2:0], red
            if (pxl_cen) begin
                rgb_raw <= {stage_hi[6:0], stage_lo};
            end
        end
    end

    // Staged pixel, held while the next one is fetched
    always_ff @(posedge clk) begin
        if (lo_valid) begin
            stage_lo <= vid_rdata;
        end
        if (hi_valid) begin
            stage_hi <= vid_rdata;
        end
    end

endmodule

`default_nettype wire

/* colmix/layer_priority.sv */
//--------------------
// Chooses the visible layer pixel and forms the palette index
// Index is registered once per pixel enable
//--------------------
`default_nettype none

module layer_priority (
    input  wire                     clk,
    input  wire                     pxl_cen,
    input  wire colmix_pkg::pixel_t gfx1_pxl,
    input  wire colmix_pkg::pixel_t gfx2_pxl,
    input  wire                     prio_mode,
    input  wire                     pal_bank,
    output colmix_pkg::pal_index_t  pal_index
);

    colmix_pkg::pixel_t front;
    colmix_pkg::pixel_t back;
    colmix_pkg::pixel_t pick;
    logic               front_opaque;
    logic               pick_layer;

    // prio_mode 1 puts layer 2 in front
    assign front = prio_mode ? gfx2_pxl : gfx1_pxl;
    assign back  = prio_mode ? gfx1_pxl : gfx2_pxl;

    assign front_opaque = front[3:0] != 4'h0;

    // Back pixel wins even when it is clear too
    assign pick = front_opaque ? front : back;

    // Layer 2 shows when in front and opaque, or behind a clear layer 1
    assign pick_layer = prio_mode == front_opaque;

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_index <= {pal_bank, pick_layer, pick};
        end
    end

endmodule

`default_nettype wire

/* colmix/colmix_regs.sv */
//--------------------
// APB slave for palette bytes and the control register
// Palette reads take one wait state, all else completes at once
// Unmapped addresses answer with pslverr
//--------------------
`default_nettype none
`include "colmix_consts.svh"

module colmix_regs (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire [`COLMIX_ADDR_W-1:0]  paddr,
    input  wire [7:0]                 pwdata,
    output logic [7:0]                prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      host_we,
    output colmix_pkg::pal_addr_t     host_addr,
    output logic [7:0]                host_wdata,
    input  wire [7:0]                 host_rdata,
    output logic                      prio_mode,
    output logic                      pal_bank
);

    colmix_pkg::apb_state_t state;
    logic                   pal_sel;
    logic                   ctrl_sel;
    logic                   setup;
    logic                   access;
    logic                   pal_read;
    logic [7:0]             ctrl_rd;

    // Address decode
    assign pal_sel  = paddr < `COLMIX_PAL_BYTES;
    assign ctrl_sel = paddr == `COLMIX_CTRL_ADDR;

    assign setup    = psel && !penable;
    assign access   = psel && penable;
    assign pal_read = access && pal_sel && !pwrite;

    // Palette read stalls one cycle for RAM data
    assign pready  = access && !(pal_read && state == colmix_pkg::APB_IDLE);
    assign pslverr = access && !pal_sel && !ctrl_sel;

    // RAM address follows paddr, so data is ready in the first access cycle
    assign host_we    = access && pwrite && pal_sel;
    assign host_addr  = paddr[9:0];
    assign host_wdata = pwdata;

    // Control readback byte
    always_comb begin
        ctrl_rd = 8'h00;
        ctrl_rd[`COLMIX_CTRL_PRIO_BIT] = prio_mode;
        ctrl_rd[`COLMIX_CTRL_BANK_BIT] = pal_bank;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= colmix_pkg::APB_IDLE;
            prdata    <= 8'h00;
            prio_mode <= 1'b0;
            pal_bank  <= 1'b0;
        end else begin
            case (state)
                colmix_pkg::APB_IDLE: begin
                    if (pal_read) begin
                        state  <= colmix_pkg::APB_READ_WAIT;
                        prdata <= host_rdata;
                    end
                end
                colmix_pkg::APB_READ_WAIT: begin
                    state <= colmix_pkg::APB_IDLE;
                end
                default: begin
                    state <= colmix_pkg::APB_IDLE;
                end
            endcase
            // Control and unmapped reads settle during setup
            if (setup) begin
                prdata <= (ctrl_sel && !pwrite) ? ctrl_rd : 8'h00;
            end
            if (access && pwrite && ctrl_sel) begin
                prio_mode <= pwdata[`COLMIX_CTRL_PRIO_BIT];
                pal_bank  <= pwdata[`COLMIX_CTRL_BANK_BIT];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/palette_ram.sv */
//--------------------
// Palette storage, one byte per address
// Host port reads and writes, video port only reads
// Both ports return data one clock after the address
//--------------------
`default_nettype none
`include "colmix_consts.svh"

module palette_ram (
    input  wire                        clk,
    input  wire                        host_we,
    input  wire colmix_pkg::pal_addr_t host_addr,
    input  wire [7:0]                  host_wdata,
    output logic [7:0]                 host_rdata,
    input  wire colmix_pkg::pal_addr_t vid_addr,
    output logic [7:0]                 vid_rdata
);

    logic [7:0] mem [`COLMIX_PAL_BYTES];

    // Host port, new data shows on a write
    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
            host_rdata     <= host_wdata;
        end else begin
            host_rdata <= mem[host_addr];
        end
    end

    // Video port
    // Bypass when the host writes the byte being fetched
    always_ff @(posedge clk) begin
        if (host_we && host_addr == vid_addr) begin
            vid_rdata <= host_wdata;
        end else begin
            vid_rdata <= mem[vid_addr];
        end
    end

endmodule

`default_nettype wire

/* common/colmix_pkg.sv */
//--------------------
// Shared types for the colour mixer datapath
// Used by the RTL and the testbench through scoped names
//--------------------
`default_nettype none

package colmix_pkg;

    // Layer pixel, group in 6..4, colour in 3..0
    // Colour 0 is transparent
    typedef logic [6:0] pixel_t;

    // Bank, layer, group, colour
    typedef logic [8:0] pal_index_t;

    // Byte address into the palette RAM
    typedef logic [9:0] pal_addr_t;

    // Blue 14..10, green 9..5, red 4..0
    typedef logic [14:0] rgb_t;

    // Which palette byte the video port is reading
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_LOW,
        FETCH_HIGH
    } fetch_state_t;

    typedef enum logic {
        APB_IDLE,
        APB_READ_WAIT
    } apb_state_t;

endpackage

`default_nettype wire

/* common/colmix_consts.svh */
//--------------------
// Address map, widths and pipeline delays of the colour mixer
// Included by any file that needs them
//--------------------
`ifndef COLMIX_CONSTS_SVH
`define COLMIX_CONSTS_SVH

// Palette size in bytes, two bytes per colour
`define COLMIX_PAL_BYTES 1024
// APB address width and control register location
`define COLMIX_ADDR_W 12
`define COLMIX_CTRL_ADDR 12'h400
// Pixel enables from layer sample to colour output
`define COLMIX_BLANK_DLY 3
// Control register bits
`define COLMIX_CTRL_PRIO_BIT 0
`define COLMIX_CTRL_BANK_BIT 1

`endif
